// File: source/ecc_cfg.svh
/*
 * Bank geometry for the ECC memory.
 * The check-bit table in ecc_pkg covers 32 data bits only, so
 * ECC_DATA_W and ECC_CODE_W cannot change on their own.
 */
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

`define ECC_BANK_WORDS 256 // Words in the bank
`define ECC_DATA_W     32  // Data bits per word
`define ECC_CODE_W     39  // Data plus 7 check bits

`endif

// File: source/ecc_pkg.sv
/*
 * SECDED types and functions for the 39/32 codeword.
 * Every data column has weight 3, so single errors (odd syndrome)
 * and double errors (even syndrome) never alias.
 */
`default_nettype none

`include "ecc_cfg.svh"

package ecc_pkg;

  localparam int unsigned CHECK_W = `ECC_CODE_W - `ECC_DATA_W;

  typedef logic [`ECC_DATA_W-1:0] data_t;
  typedef logic [`ECC_CODE_W-1:0] code_t; // [38:32] check, [31:0] data

  typedef struct packed {
    logic multi;
    logic single;
  } ecc_err_t;

  // Check bits touched by each data bit with data bit 0 first
  localparam logic [CHECK_W-1:0] H_COL [`ECC_DATA_W] = '{
    7'h07, 7'h0b, 7'h0d, 7'h0e, 7'h13, 7'h15, 7'h16, 7'h19,
    7'h1a, 7'h1c, 7'h23, 7'h25, 7'h26, 7'h29, 7'h2a, 7'h2c,
    7'h31, 7'h32, 7'h34, 7'h38, 7'h43, 7'h45, 7'h46, 7'h49,
    7'h4a, 7'h4c, 7'h51, 7'h52, 7'h54, 7'h58, 7'h61, 7'h62
  };

  function automatic code_t secded_encode(input data_t data);
    logic [CHECK_W-1:0] check;
    check = '0;
    for (int i = 0; i < `ECC_DATA_W; i++) begin
      if (data[i]) begin
        check = check ^ H_COL[i];
      end
    end
    return {check, data};
  endfunction

  // Returns the corrected data word and reports what was found in err
  function automatic data_t secded_decode(input code_t code, output ecc_err_t err);
    code_t              recoded;
    logic [CHECK_W-1:0] syndrome;
    data_t              data;
    data     = code[`ECC_DATA_W-1:0];
    recoded  = secded_encode(data);
    syndrome = recoded[`ECC_CODE_W-1:`ECC_DATA_W] ^ code[`ECC_CODE_W-1:`ECC_DATA_W];
    err      = '0;
    if (syndrome != '0) begin
      err.multi = 1'b1; // Unless the syndrome names a single column
      if ($countones(syndrome) == 1) begin
        err.single = 1'b1; // Only a check bit flipped
        err.multi  = 1'b0;
      end
      for (int i = 0; i < `ECC_DATA_W; i++) begin
        if (syndrome == H_COL[i]) begin
          data[i]    = ~data[i];
          err.single = 1'b1;
          err.multi  = 1'b0;
        end
      end
    end
    return data;
  endfunction

endpackage

`default_nettype wire

// File: source/bank_pkg.sv
/*
 * Address, byte-enable and FSM state types of the bank access path.
 */
`default_nettype none

`include "ecc_cfg.svh"

package bank_pkg;

  typedef logic [$clog2(`ECC_BANK_WORDS)-1:0] word_addr_t;
  typedef logic [`ECC_DATA_W/8-1:0]           be_t;

  typedef enum logic {
    NORMAL,
    WRITE_BACK // Second cycle of a partial store
  } store_state_e;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    FIX
  } scrub_state_e;

endpackage

`default_nettype wire

// File: source/bank_if.sv
/*
 * Single-port bank access, codewords only.
 * rdata is valid the cycle after a read request.
 */
`timescale 1ns/1ps
`default_nettype none

interface bank_if;
  import bank_pkg::*;
  import ecc_pkg::*;

  logic       req;
  logic       we;    // 1 writes wdata
  word_addr_t addr;
  code_t      wdata;
  code_t      rdata;

  modport initiator (output req, we, addr, wdata, input rdata);
  modport target    (input req, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// File: source/sram_bank.sv
/*
 * Single-port codeword array, one-cycle read latency.
 * A set write_mask_i bit keeps that stored bit unchanged on writes.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_cfg.svh"

module sram_bank (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ecc_pkg::code_t write_mask_i,
  bank_if.target         mem
);
  import ecc_pkg::*;

  code_t mem_q [`ECC_BANK_WORDS] = '{default: '0}; // All-zero is a valid codeword

  always_ff @(posedge clk_i) begin : proc_write
    if (mem.req && mem.we) begin
      mem_q[mem.addr] <= (mem.wdata & ~write_mask_i) | (mem_q[mem.addr] & write_mask_i);
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      mem.rdata <= '0;
    end else if (mem.req && !mem.we) begin
      mem.rdata <= mem_q[mem.addr];
    end
  end

endmodule

`default_nettype wire

// File: source/ecc_scrubber.sv
/*
 * Port accesses always win the bank. The scrub walk only uses idle
 * cycles, so a busy port can delay scrubbing without bound.
 * A fix lost to the port is retried by re-reading the same address.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_cfg.svh"

module ecc_scrubber (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      scrub_trigger_i,
  output logic      fix_o,
  output logic      uncorrectable_o,
  bank_if.target    port,
  bank_if.initiator mem
);
  import ecc_pkg::*;
  import bank_pkg::*;

  localparam word_addr_t LAST_ADDR = word_addr_t'(`ECC_BANK_WORDS - 1);

  scrub_state_e state_d, state_q;
  word_addr_t   addr_d, addr_q, addr_next;
  code_t        fix_code_q;
  data_t        scrub_data;
  ecc_err_t     scrub_err;
  logic         port_idle;

  assign port_idle   = !port.req;
  assign port.rdata  = mem.rdata; // No added read latency
  assign addr_next   = (addr_q == LAST_ADDR) ? '0 : word_addr_t'(addr_q + 1'b1);

  always_comb begin : proc_decode
    scrub_data = secded_decode(mem.rdata, scrub_err);
  end

  always_comb begin : proc_fsm
    state_d         = state_q;
    addr_d          = addr_q;
    fix_o           = 1'b0;
    uncorrectable_o = 1'b0;
    mem.req         = port.req;
    mem.we          = port.we;
    mem.addr        = port.addr;
    mem.wdata       = port.wdata;
    unique case (state_q)
      IDLE: begin
        if (scrub_trigger_i && port_idle) begin
          mem.req  = 1'b1; // Scrub read
          mem.we   = 1'b0;
          mem.addr = addr_q;
          state_d  = CHECK;
        end
      end
      CHECK: begin
        // Bank data here is still our own read
        state_d = IDLE;
        if (scrub_err.single) begin
          // A port store to this word now would make the fix stale
          if (!(port.req && port.we && port.addr == addr_q)) begin
            state_d = FIX;
          end
        end else begin
          addr_d          = addr_next;
          uncorrectable_o = scrub_err.multi;
        end
      end
      FIX: begin
        state_d = IDLE; // Stolen cycle leaves addr_q for a retry
        if (port_idle) begin
          mem.req   = 1'b1;
          mem.we    = 1'b1;
          mem.addr  = addr_q;
          mem.wdata = fix_code_q;
          fix_o     = 1'b1;
          addr_d    = addr_next;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  always_ff @(posedge clk_i) begin : proc_fix_code
    if (state_q == CHECK) begin
      fix_code_q <= secded_encode(scrub_data); // Re-encoded corrected word
    end
  end

endmodule

`default_nettype wire

// File: source/ecc_sram_wrap.sv
/*
 * Req/gnt port onto a codeword bank. Full stores write at once.
 * Partial stores read first, then write back the merged word while
 * gnt_o is low; the requester must hold its request meanwhile.
 */
`timescale 1ns/1ps
`default_nettype none

module ecc_sram_wrap (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  logic [31:0]    addr_i,  // Byte address
  input  ecc_pkg::data_t wdata_i,
  input  bank_pkg::be_t  be_i,
  output ecc_pkg::data_t rdata_o,
  output logic           gnt_o,
  output logic           single_error_o,
  output logic           multi_error_o,
  bank_if.initiator      bank
);
  import ecc_pkg::*;
  import bank_pkg::*;

  localparam int unsigned ADDR_LSB = 2;
  localparam int unsigned ADDR_MSB = ADDR_LSB + $bits(word_addr_t) - 1;

  store_state_e state_d, state_q;
  word_addr_t   addr_q;
  data_t        wdata_q;
  be_t          be_q;
  data_t        loaded;
  data_t        be_bits;
  data_t        merged;
  ecc_err_t     err;
  logic         partial;
  logic         rvalid_q;

  assign partial = req_i && we_i && (be_i != '1);

  always_comb begin : proc_decode
    loaded = secded_decode(bank.rdata, err);
  end

  always_comb begin : proc_merge
    for (int b = 0; b < $bits(be_t); b++) begin
      be_bits[8*b +: 8] = {8{be_q[b]}};
    end
    merged = (be_bits & wdata_q) | (~be_bits & loaded);
  end

  assign rdata_o        = loaded;
  assign single_error_o = err.single && rvalid_q;
  assign multi_error_o  = err.multi && rvalid_q;

  always_comb begin : proc_store_fsm
    state_d    = NORMAL;
    gnt_o      = 1'b1;
    bank.req   = req_i;
    bank.we    = we_i;
    bank.addr  = addr_i[ADDR_MSB:ADDR_LSB];
    bank.wdata = secded_encode(wdata_i);
    unique case (state_q)
      NORMAL: begin
        if (partial) begin
          bank.we = 1'b0; // Fetch the old word first
          state_d = WRITE_BACK;
        end
      end
      WRITE_BACK: begin
        gnt_o      = 1'b0;
        bank.req   = 1'b1;
        bank.we    = 1'b1;
        bank.addr  = addr_q;
        bank.wdata = secded_encode(merged);
      end
      default: state_d = NORMAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
    if (!rst_ni) begin
      state_q  <= NORMAL;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= req_i && gnt_o && !we_i; // Accepted load
    end
  end

  // Partial store buffers
  always_ff @(posedge clk_i) begin : proc_buffer
    if (partial && gnt_o) begin
      addr_q  <= addr_i[ADDR_MSB:ADDR_LSB];
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

endmodule

`default_nettype wire

// File: source/ecc_sram_top.sv
/*
 * ECC-protected bank with a background scrubber.
 * write_mask_i is a test port and is tied to zero in normal use.
 */
`timescale 1ns/1ps
`default_nettype none

module ecc_sram_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  logic [31:0]    addr_i,
  input  ecc_pkg::data_t wdata_i,
  input  bank_pkg::be_t  be_i,
  output ecc_pkg::data_t rdata_o,
  output logic           gnt_o,
  output logic           single_error_o,
  output logic           multi_error_o,
  input  logic           scrub_trigger_i,
  output logic           scrub_fix_o,
  output logic           scrub_uncorrectable_o,
  input  ecc_pkg::code_t write_mask_i // 1 holds the stored bit
);

  bank_if wrap_bus ();
  bank_if mem_bus ();

  ecc_sram_wrap i_wrap (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .rdata_o        (rdata_o),
    .gnt_o          (gnt_o),
    .single_error_o (single_error_o),
    .multi_error_o  (multi_error_o),
    .bank           (wrap_bus.initiator)
  );

  ecc_scrubber i_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_trigger_i (scrub_trigger_i),
    .fix_o           (scrub_fix_o),
    .uncorrectable_o (scrub_uncorrectable_o),
    .port            (wrap_bus.target),
    .mem             (mem_bus.initiator)
  );

  sram_bank i_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .write_mask_i (write_mask_i),
    .mem          (mem_bus.target)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
/*
 * Free-running testbench clock and active-low reset.
 * Reset is released just after a rising edge, so flops never see the edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : proc_clock
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin : proc_reset
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1; // Lands after the flops have sampled this edge
  end

endmodule

`default_nettype wire

// File: verif/ecc_sram_props.sv
/*
 * Protocol properties of the ECC bank top level, attached by bind.
 * All checks are idle while rst_ni is low.
 */
`timescale 1ns/1ps
`default_nettype none

module ecc_sram_props (
  input logic clk_i,
  input logic rst_ni,
  input logic gnt_o,
  input logic single_error_o,
  input logic multi_error_o,
  input logic scrub_fix_o,
  input logic scrub_uncorrectable_o
);

  // Only one write-back cycle follows a partial store
  gnt_gap_a: assert property (@(posedge clk_i) disable iff (!rst_ni) !gnt_o |=> gnt_o)
    else $error("gnt_o low in two consecutive cycles");

  flags_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(single_error_o && multi_error_o))
    else $error("single and multi error flags high together");

  fix_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrub_fix_o |=> !scrub_fix_o)
    else $error("scrub_fix_o wider than one cycle");

  unc_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrub_uncorrectable_o |=> !scrub_uncorrectable_o)
    else $error("scrub_uncorrectable_o wider than one cycle");

endmodule

`default_nettype wire

// File: verif/tb_ecc_sram.sv
/*
 * Random traffic over the first 16 words, then mask-injected faults
 * and one scrub pass. The model keeps its own copy of the check bits.
 * Words outside the window are never written and stay all-zero.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_cfg.svh"

module tb_ecc_sram;

  localparam int unsigned WINDOW          = 16;
  localparam int unsigned N_RANDOM        = 300;
  localparam int unsigned N_FAULT         = 10;  // Per fault kind
  localparam int unsigned N_TRANS         = N_RANDOM + 6 * N_FAULT + 3;
  localparam int unsigned WATCHDOG_CYCLES = 20 * N_TRANS + 2000;
  localparam int unsigned SCRUB_LIMIT     = 2 * `ECC_BANK_WORDS;

  // Check bits fed by each data bit with data bit 0 first
  localparam logic [6:0] CHECK_COL [32] = '{
    7'h07, 7'h0b, 7'h0d, 7'h0e, 7'h13, 7'h15, 7'h16, 7'h19,
    7'h1a, 7'h1c, 7'h23, 7'h25, 7'h26, 7'h29, 7'h2a, 7'h2c,
    7'h31, 7'h32, 7'h34, 7'h38, 7'h43, 7'h45, 7'h46, 7'h49,
    7'h4a, 7'h4c, 7'h51, 7'h52, 7'h54, 7'h58, 7'h61, 7'h62
  };

  logic        clk, rst_n;
  logic        req, we, gnt;
  logic [31:0] addr, wdata, rdata;
  logic [3:0]  be;
  logic        single_err, multi_err;
  logic        scrub_trigger, scrub_fix, scrub_unc;
  logic [38:0] write_mask;

  logic [31:0] lfsr_state = 32'h7354e281;
  logic [38:0] code_m [WINDOW]; // Stored codeword per word
  logic [31:0] data_m [WINDOW]; // Data last written on purpose
  int unsigned errors  = 0;
  int unsigned n_trans = 0;
  logic        gnt_prev = 1'b1;
  logic        fix_prev = 1'b0;
  logic        unc_prev = 1'b0;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(8)) i_clock (.clk_o(clk), .rst_no(rst_n));

  ecc_sram_top i_dut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .req_i                 (req),
    .we_i                  (we),
    .addr_i                (addr),
    .wdata_i               (wdata),
    .be_i                  (be),
    .rdata_o               (rdata),
    .gnt_o                 (gnt),
    .single_error_o        (single_err),
    .multi_error_o         (multi_err),
    .scrub_trigger_i       (scrub_trigger),
    .scrub_fix_o           (scrub_fix),
    .scrub_uncorrectable_o (scrub_unc),
    .write_mask_i          (write_mask)
  );

  bind ecc_sram_top ecc_sram_props i_props (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .gnt_o                 (gnt_o),
    .single_error_o        (single_error_o),
    .multi_error_o         (multi_error_o),
    .scrub_fix_o           (scrub_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  function automatic logic [38:0] model_encode(input logic [31:0] d);
    logic [6:0] chk;
    chk = '0;
    for (int i = 0; i < 32; i++) begin
      if (d[i]) begin
        chk = chk ^ CHECK_COL[i];
      end
    end
    return {chk, d};
  endfunction

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic note_mismatch(input string msg);
    errors++;
    $display("FAIL @%0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // One port transaction checked one cycle after acceptance
  task automatic access(input logic wr, input int unsigned idx, input logic [31:0] d,
                        input logic [3:0] ben, input logic [38:0] mask);
    logic [31:0] byte_bits;
    logic [31:0] new_data;
    logic [38:0] new_code;
    int unsigned nerr;
    byte_bits = {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
    @(negedge clk);
    req        = 1'b1;
    we         = wr;
    addr       = idx << 2;
    wdata      = d;
    be         = ben;
    write_mask = mask;
    while (!gnt) begin
      @(negedge clk);
    end
    @(negedge clk); // Accepted at the edge just passed
    n_trans++;
    if (wr) begin
      new_data    = (d & byte_bits) | (data_m[idx] & ~byte_bits);
      new_code    = model_encode(new_data);
      code_m[idx] = (new_code & ~mask) | (code_m[idx] & mask); // Masked bits keep old value
      data_m[idx] = new_data;
      if (ben != 4'hf) begin
        if (gnt) begin
          note_mismatch($sformatf("gnt_o high in write-back of word %0d", idx));
        end
        @(negedge clk);
      end
      if (!gnt) begin
        note_mismatch($sformatf("gnt_o low after store to word %0d", idx));
      end
    end else begin
      nerr = $countones(code_m[idx] ^ model_encode(data_m[idx]));
      if (single_err != (nerr == 1) || multi_err != (nerr == 2)) begin
        note_mismatch($sformatf("word %0d flags s=%b m=%b, expected %0d bad bits",
                                idx, single_err, multi_err, nerr));
      end
      if (nerr < 2 && rdata != data_m[idx]) begin
        note_mismatch($sformatf("word %0d read %h, expected %h", idx, rdata, data_m[idx]));
      end
    end
    req        = 1'b0;
    write_mask = '0;
  endtask

  // Full store whose codeword differs from the stored one in nbits held bits
  task automatic inject_fault(input int unsigned idx, input int unsigned nbits);
    logic [31:0] d;
    logic [38:0] diff;
    logic [38:0] mask;
    int unsigned start;
    int unsigned taken;
    int unsigned j;
    do begin
      d    = rand_bits(32);
      diff = model_encode(d) ^ code_m[idx];
    end while ($countones(diff) < nbits);
    start = rand_bits(6) % 39;
    mask  = '0;
    taken = 0;
    for (int unsigned i = 0; i < 39; i++) begin
      j = (start + i) % 39;
      if (diff[j] && taken < nbits) begin
        mask[j] = 1'b1;
        taken++;
      end
    end
    access(1'b1, idx, d, 4'hf, mask);
  endtask

  task automatic check_quiet_outputs(input string when);
    if (!gnt || single_err || multi_err || scrub_fix || scrub_unc) begin
      note_mismatch($sformatf("%s: gnt=%b s=%b m=%b fix=%b unc=%b", when,
                              gnt, single_err, multi_err, scrub_fix, scrub_unc));
    end
  endtask

  // Protocol rules on gnt, error flags and scrub pulses
  always @(negedge clk) begin : protocol_monitor
    if (rst_n) begin
      if (!gnt && !gnt_prev) begin
        note_failure("gnt_o stayed low for two cycles");
      end
      if (single_err && multi_err) begin
        note_failure("single and multi error flags were high together");
      end
      if ((scrub_fix && fix_prev) || (scrub_unc && unc_prev)) begin
        note_failure("a scrub pulse lasted more than one cycle");
      end
    end
    gnt_prev <= gnt;
    fix_prev <= scrub_fix;
    unc_prev <= scrub_unc;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    int unsigned idx;
    int unsigned kind;
    int unsigned wait_cycles;
    logic [3:0]  ben;
    req           = 1'b0;
    we            = 1'b0;
    addr          = '0;
    wdata         = '0;
    be            = '0;
    scrub_trigger = 1'b0;
    write_mask    = '0;
    for (int i = 0; i < WINDOW; i++) begin
      code_m[i] = '0; // All-zero start is a valid codeword
      data_m[i] = '0;
    end

    @(negedge clk);
    while (!rst_n) begin
      check_quiet_outputs("during reset");
      @(negedge clk);
    end
    check_quiet_outputs("after reset");

    for (int n = 0; n < N_RANDOM; n++) begin
      idx  = rand_bits(4);
      kind = rand_bits(2);
      if (kind == 1) begin
        access(1'b1, idx, rand_bits(32), 4'hf, '0);
      end else if (kind == 2) begin
        ben = 4'(rand_bits(4));
        access(1'b1, idx, rand_bits(32), ben, '0);
      end else begin
        access(1'b0, idx, '0, 4'hf, '0);
      end
    end

    // Single then double faults that a clean full store repairs
    for (int unsigned k = 1; k <= 2; k++) begin
      for (int n = 0; n < N_FAULT; n++) begin
        idx = rand_bits(4);
        inject_fault(idx, k);
        access(1'b0, idx, '0, 4'hf, '0);
        access(1'b1, idx, rand_bits(32), 4'hf, '0);
      end
    end

    idx = rand_bits(4);
    inject_fault(idx, 1);
    @(negedge clk);
    scrub_trigger = 1'b1;
    wait_cycles   = 0;
    while (!scrub_fix && wait_cycles < SCRUB_LIMIT) begin
      @(negedge clk);
      if (scrub_unc) begin
        note_mismatch("scrub_uncorrectable_o pulsed with no double fault stored");
      end
      wait_cycles++;
    end
    scrub_trigger = 1'b0;
    if (scrub_fix) begin
      code_m[idx] = model_encode(data_m[idx]); // Write-back lands at the next edge
    end else begin
      note_failure($sformatf("scrubber gave no fix pulse within %0d cycles", SCRUB_LIMIT));
    end
    access(1'b0, idx, '0, 4'hf, '0);

    repeat (2) @(negedge clk);
    $display("%0d transactions, %0d errors", n_trans, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/ecc_pkg.sv
source/bank_pkg.sv
source/bank_if.sv
source/sram_bank.sv
source/ecc_scrubber.sv
source/ecc_sram_wrap.sv
source/ecc_sram_top.sv
verif/tb_clock.sv
verif/ecc_sram_props.sv
verif/tb_ecc_sram.sv

// File: Makefile
SIM  := obj_dir/Vtb_ecc_sram
SRCS := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) src.f
	verilator --binary --assert --top-module tb_ecc_sram -f src.f

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
